/* mem_pkg.sv */
package mem_pkg;

  // Word address width. Gives 256 words of storage.
  localparam int ADDR_W = 8;

  localparam int DATA_W = 32;                      // Width of one memory word.

  // The SRAM spends this many cycles in BUSY before it shows a response.
  localparam int WAIT_CYCLES = 3;

  localparam int WAIT_W = $clog2(WAIT_CYCLES + 1); // Holds any busy cycle count.

  // Requester 0 is the fetch port and requester 1 is the data port.
  localparam int NUM_REQ = 2;
  localparam int REQ_IDX_W = (NUM_REQ > 1) ? $clog2(NUM_REQ) : 1;
  localparam int FETCH_IDX = 0;                    // Arbiter slot of the fetch port.
  localparam int DATA_IDX = 1;                     // Arbiter slot of the data port.

  // One request as it travels from a port through the arbiter to the SRAM.
  typedef struct packed {
    logic              write;                      // High for a store.
    logic [ADDR_W-1:0] addr;                       // Word address.
    logic [DATA_W-1:0] wdata;                      // Store data. Loads leave it at zero.
  } mem_req_t;

  // One response. On a store it carries the word that was overwritten.
  typedef struct packed {
    logic [DATA_W-1:0] rdata;
  } mem_rsp_t;

  // SRAM control states.
  // IDLE takes a request, BUSY counts wait states and RESP holds the response.
  typedef enum logic [1:0] {
    IDLE = 2'b00,
    BUSY = 2'b01,
    RESP = 2'b10
  } sram_state_t;

endpackage

/* sram_wait.sv */
`timescale 1ns/100ps

module sram_wait (
  input  logic              clk,
  input  logic              rst,

  input  logic              req_valid_i,  // Request channel.
  output logic              req_ready_o,
  input  mem_pkg::mem_req_t req_i,

  output logic              rsp_valid_o,  // Response channel.
  input  logic              rsp_ready_i,
  output mem_pkg::mem_rsp_t rsp_o
);

  localparam int DEPTH = 2 ** mem_pkg::ADDR_W;

  logic [mem_pkg::DATA_W-1:0] mem_q [DEPTH];  // The storage array.
  logic [mem_pkg::DATA_W-1:0] rdata_q;        // Word captured at acceptance.
  logic [mem_pkg::WAIT_W-1:0] cnt_q;          // Busy cycles spent so far.
  mem_pkg::sram_state_t       state_q;
  mem_pkg::sram_state_t       state_d;
  logic                       accept;
  logic                       wait_done;

  // Words the hex file does not cover hold a fixed tag plus their own address.
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem_q[i] = 32'hC0DE_0000 + i;
    end
    $readmemh("mem_init.hex", mem_q);
  end

  assign req_ready_o = (state_q == mem_pkg::IDLE);  // Only an idle SRAM takes work.
  assign rsp_valid_o = (state_q == mem_pkg::RESP);
  assign rsp_o.rdata = rdata_q;

  assign accept    = req_valid_i && req_ready_o;
  assign wait_done = (cnt_q == mem_pkg::WAIT_CYCLES - 1);  // Last busy cycle.

  // The array is read and written at acceptance.
  // A store therefore returns the old word as its acknowledge.
  always @(posedge clk) begin
    if (accept) begin
      rdata_q <= mem_q[req_i.addr];
      if (req_i.write) begin
        mem_q[req_i.addr] <= req_i.wdata;
      end
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      mem_pkg::IDLE: begin
        if (req_valid_i) begin
          state_d = mem_pkg::BUSY;  // Ready is high here, so valid means accepted.
        end
      end
      mem_pkg::BUSY: begin
        if (wait_done) begin
          state_d = mem_pkg::RESP;
        end
      end
      mem_pkg::RESP: begin
        if (rsp_ready_i) begin
          state_d = mem_pkg::IDLE;  // Without ready the response just holds.
        end
      end
      default: begin
        state_d = mem_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state_q <= mem_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // The counter restarts on every acceptance and runs only while BUSY.
  // BUSY lasts exactly WAIT_CYCLES cycles.
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      cnt_q <= '0;
    end else if (accept) begin
      cnt_q <= '0;
    end else if (state_q == mem_pkg::BUSY) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

endmodule

/* mem_arbiter.sv */
`timescale 1ns/100ps

module mem_arbiter (
  input  logic                                      clk,
  input  logic                                      rst,

  input  logic [mem_pkg::NUM_REQ-1:0]               req_valid_i,  // Requester side.
  output logic [mem_pkg::NUM_REQ-1:0]               req_ready_o,
  input  mem_pkg::mem_req_t [mem_pkg::NUM_REQ-1:0]  req_i,
  output logic [mem_pkg::NUM_REQ-1:0]               rsp_valid_o,
  input  logic [mem_pkg::NUM_REQ-1:0]               rsp_ready_i,

  output logic                                      mem_req_valid_o,  // SRAM side.
  input  logic                                      mem_req_ready_i,
  output mem_pkg::mem_req_t                         mem_req_o,
  input  logic                                      mem_rsp_valid_i,
  output logic                                      mem_rsp_ready_o
);

  logic [mem_pkg::REQ_IDX_W-1:0] last_q;   // Most recent winner.
  logic [mem_pkg::REQ_IDX_W-1:0] owner_q;  // Requester that holds the SRAM.
  logic                          locked_q; // High from acceptance to response handshake.
  logic [mem_pkg::REQ_IDX_W-1:0] pick;     // Round-robin choice while unlocked.
  logic                          found;    // Some requester is asking.
  int unsigned                   cand;
  logic                          req_take;
  logic                          rsp_take;

  // The search starts one past the last winner.
  // So on a tie the last winner comes last.
  always_comb begin
    pick  = last_q;
    found = 1'b0;
    cand  = 0;
    for (int k = 1; k <= mem_pkg::NUM_REQ; k++) begin
      cand = (int'(last_q) + k) % mem_pkg::NUM_REQ;
      if (!found && req_valid_i[cand]) begin
        pick  = cand[mem_pkg::REQ_IDX_W-1:0];
        found = 1'b1;
      end
    end
  end

  // No new request goes out while a transaction is in flight.
  assign mem_req_valid_o = !locked_q && found;
  assign mem_req_o       = req_i[pick];
  assign mem_rsp_ready_o = locked_q && rsp_ready_i[owner_q];  // Owner's ready only.

  // Only the chosen requester sees ready, and only the owner sees a response.
  always_comb begin
    for (int i = 0; i < mem_pkg::NUM_REQ; i++) begin
      req_ready_o[i] = !locked_q && (int'(pick) == i) && mem_req_ready_i;
      rsp_valid_o[i] = locked_q && (int'(owner_q) == i) && mem_rsp_valid_i;
    end
  end

  assign req_take = mem_req_valid_o && mem_req_ready_i;
  assign rsp_take = mem_rsp_valid_i && mem_rsp_ready_o;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      locked_q <= 1'b0;
      owner_q  <= '0;
      last_q   <= '0;
    end else if (req_take) begin
      locked_q <= 1'b1;  // Winner keeps the SRAM until its response is taken.
      owner_q  <= pick;
      last_q   <= pick;
    end else if (rsp_take) begin
      locked_q <= 1'b0;
    end
  end

endmodule

/* fetch_port.sv */
`timescale 1ns/100ps

module fetch_port (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       redirect_i,     // Loads a new PC and flushes.
  input  logic [mem_pkg::ADDR_W-1:0] redirect_pc_i,
  output logic                       instr_valid_o,  // Instruction stream to the core.
  input  logic                       instr_ready_i,
  output logic [mem_pkg::DATA_W-1:0] instr_o,
  output logic [mem_pkg::ADDR_W-1:0] instr_pc_o,
  output logic                       mem_req_valid_o,
  input  logic                       mem_req_ready_i,
  output mem_pkg::mem_req_t          mem_req_o,
  input  logic                       mem_rsp_valid_i,
  output logic                       mem_rsp_ready_o,
  input  mem_pkg::mem_rsp_t          mem_rsp_i
);

  // One buffered instruction and the PC it was fetched from.
  typedef struct packed {
    logic [mem_pkg::DATA_W-1:0] word;
    logic [mem_pkg::ADDR_W-1:0] pc;
  } fetch_entry_t;

  fetch_entry_t               fifo_q [2];   // Two-entry instruction buffer.
  logic                       wr_ptr_q;
  logic                       rd_ptr_q;
  logic [1:0]                 count_q;      // Valid entries in the buffer.
  logic [mem_pkg::ADDR_W-1:0] pc_q;         // Next PC to request.
  logic                       req_vld_q;    // Request raised and not yet taken.
  logic                       req_stale_q;  // Epoch bit of the raised request.
  logic [mem_pkg::ADDR_W-1:0] req_pc_q;
  logic                       infl_q;       // Request accepted by the SRAM.
  logic                       infl_stale_q; // Epoch bit of the in-flight request.
  logic [mem_pkg::ADDR_W-1:0] infl_pc_q;
  logic [1:0]                 reserved;     // Entries filled or promised.
  logic                       launch;
  logic                       req_take;
  logic                       rsp_take;
  logic                       rsp_keep;
  logic                       deq;

  assign reserved = count_q + 2'(infl_q) + 2'(req_vld_q);
  assign launch   = !req_vld_q && !redirect_i && (reserved < 2'd2);
  assign req_take = mem_req_valid_o && mem_req_ready_i;
  assign rsp_take = mem_rsp_valid_i && infl_q;
  assign rsp_keep = rsp_take && !infl_stale_q && !redirect_i;  // Old-epoch words drop.
  assign deq      = instr_valid_o && instr_ready_i;

  assign mem_req_valid_o = req_vld_q;  // Registered, so it stays stable until taken.
  assign mem_req_o       = '{write: 1'b0, addr: req_pc_q, wdata: '0};
  assign mem_rsp_ready_o = 1'b1;       // Responses are never back-pressured.

  assign instr_valid_o = (count_q != 2'd0);
  assign instr_o       = fifo_q[rd_ptr_q].word;
  assign instr_pc_o    = fifo_q[rd_ptr_q].pc;

  always_ff @(posedge clk) begin
    if (launch) begin
      req_pc_q <= pc_q;
    end
    if (req_take) begin
      infl_pc_q <= req_pc_q;
    end
    if (rsp_keep) begin
      fifo_q[wr_ptr_q] <= '{word: mem_rsp_i.rdata, pc: infl_pc_q};
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc_q         <= '0;
      req_vld_q    <= 1'b0;
      req_stale_q  <= 1'b0;
      infl_q       <= 1'b0;
      infl_stale_q <= 1'b0;
    end else begin
      if (redirect_i) begin
        pc_q <= redirect_pc_i;
      end else if (launch) begin
        pc_q <= pc_q + 1'b1;
      end
      if (launch) begin
        req_vld_q   <= 1'b1;
        req_stale_q <= 1'b0;
      end else begin
        if (req_take) begin
          req_vld_q <= 1'b0;
        end
        if (redirect_i) begin
          req_stale_q <= 1'b1;  // A raised request cannot be withdrawn, only marked.
        end
      end
      if (req_take) begin
        infl_q       <= 1'b1;
        infl_stale_q <= req_stale_q || redirect_i;
      end else begin
        if (rsp_take) begin
          infl_q <= 1'b0;
        end
        if (redirect_i) begin
          infl_stale_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else if (redirect_i) begin
      wr_ptr_q <= 1'b0;  // Flush wins over any write or read this cycle.
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      wr_ptr_q <= wr_ptr_q ^ rsp_keep;
      rd_ptr_q <= rd_ptr_q ^ deq;
      count_q  <= count_q + 2'(rsp_keep) - 2'(deq);
    end
  end

endmodule

/* data_port.sv */
`timescale 1ns/100ps

module data_port (
  input  logic                       clk,
  input  logic                       rst,

  input  logic                       dat_valid_i,  // Load or store from the core.
  output logic                       dat_ready_o,
  input  mem_pkg::mem_req_t          dat_req_i,
  output logic                       dat_done_o,   // One-cycle completion strobe.
  output logic [mem_pkg::DATA_W-1:0] dat_rdata_o,

  output logic                       mem_req_valid_o,  // Toward the arbiter.
  input  logic                       mem_req_ready_i,
  output mem_pkg::mem_req_t          mem_req_o,
  input  logic                       mem_rsp_valid_i,
  output logic                       mem_rsp_ready_o,
  input  mem_pkg::mem_rsp_t          mem_rsp_i
);

  mem_pkg::mem_req_t          req_q;      // The held access.
  logic [mem_pkg::DATA_W-1:0] rdata_q;    // Word from the last response.
  logic                       pend_q;     // An access is held.
  logic                       issued_q;   // The SRAM has accepted it.
  logic                       done_q;
  logic                       dat_take;
  logic                       req_take;
  logic                       rsp_take;

  assign dat_ready_o = !pend_q;  // One access at a time.
  assign dat_take    = dat_valid_i && dat_ready_o;

  // The held request stays on the bus until the arbiter lets it through.
  assign mem_req_valid_o = pend_q && !issued_q;
  assign mem_req_o       = req_q;
  assign req_take        = mem_req_valid_o && mem_req_ready_i;

  assign mem_rsp_ready_o = 1'b1;                        // The response is always taken.
  assign rsp_take        = mem_rsp_valid_i && issued_q;

  assign dat_done_o  = done_q;
  assign dat_rdata_o = rdata_q;

  always_ff @(posedge clk) begin
    if (dat_take) begin
      req_q <= dat_req_i;
    end
    if (rsp_take) begin
      rdata_q <= mem_rsp_i.rdata;  // A store returns the word it replaced.
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pend_q   <= 1'b0;
      issued_q <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      done_q <= rsp_take;  // High for the one cycle after the handshake.
      if (dat_take) begin
        pend_q <= 1'b1;
      end else if (rsp_take) begin
        pend_q <= 1'b0;
      end
      if (req_take) begin
        issued_q <= 1'b1;
      end else if (rsp_take) begin
        issued_q <= 1'b0;
      end
    end
  end

endmodule

/* mem_subsys.sv */
`timescale 1ns/100ps

module mem_subsys (
  input  logic                       clk,
  input  logic                       rst,

  input  logic                       redirect_i,     // Fetch side.
  input  logic [mem_pkg::ADDR_W-1:0] redirect_pc_i,
  output logic                       instr_valid_o,
  input  logic                       instr_ready_i,
  output logic [mem_pkg::DATA_W-1:0] instr_o,
  output logic [mem_pkg::ADDR_W-1:0] instr_pc_o,

  input  logic                       dat_valid_i,    // Data side.
  output logic                       dat_ready_o,
  input  mem_pkg::mem_req_t          dat_req_i,
  output logic                       dat_done_o,
  output logic [mem_pkg::DATA_W-1:0] dat_rdata_o
);

  logic [mem_pkg::NUM_REQ-1:0]              arb_req_valid;  // One bit per requester.
  logic [mem_pkg::NUM_REQ-1:0]              arb_req_ready;
  mem_pkg::mem_req_t [mem_pkg::NUM_REQ-1:0] arb_req;
  logic [mem_pkg::NUM_REQ-1:0]              arb_rsp_valid;
  logic [mem_pkg::NUM_REQ-1:0]              arb_rsp_ready;

  logic                                     mem_req_valid;  // Arbiter to SRAM.
  logic                                     mem_req_ready;
  mem_pkg::mem_req_t                        mem_req;
  logic                                     mem_rsp_valid;
  logic                                     mem_rsp_ready;
  mem_pkg::mem_rsp_t                        mem_rsp;        // Shared by both ports.

  fetch_port i_fetch (
    .clk             (clk),
    .rst             (rst),
    .redirect_i      (redirect_i),
    .redirect_pc_i   (redirect_pc_i),
    .instr_valid_o   (instr_valid_o),
    .instr_ready_i   (instr_ready_i),
    .instr_o         (instr_o),
    .instr_pc_o      (instr_pc_o),
    .mem_req_valid_o (arb_req_valid[mem_pkg::FETCH_IDX]),
    .mem_req_ready_i (arb_req_ready[mem_pkg::FETCH_IDX]),
    .mem_req_o       (arb_req[mem_pkg::FETCH_IDX]),
    .mem_rsp_valid_i (arb_rsp_valid[mem_pkg::FETCH_IDX]),
    .mem_rsp_ready_o (arb_rsp_ready[mem_pkg::FETCH_IDX]),
    .mem_rsp_i       (mem_rsp)
  );

  data_port i_data (
    .clk             (clk),
    .rst             (rst),
    .dat_valid_i     (dat_valid_i),
    .dat_ready_o     (dat_ready_o),
    .dat_req_i       (dat_req_i),
    .dat_done_o      (dat_done_o),
    .dat_rdata_o     (dat_rdata_o),
    .mem_req_valid_o (arb_req_valid[mem_pkg::DATA_IDX]),
    .mem_req_ready_i (arb_req_ready[mem_pkg::DATA_IDX]),
    .mem_req_o       (arb_req[mem_pkg::DATA_IDX]),
    .mem_rsp_valid_i (arb_rsp_valid[mem_pkg::DATA_IDX]),
    .mem_rsp_ready_o (arb_rsp_ready[mem_pkg::DATA_IDX]),
    .mem_rsp_i       (mem_rsp)
  );

  mem_arbiter i_arb (
    .clk             (clk),
    .rst             (rst),
    .req_valid_i     (arb_req_valid),
    .req_ready_o     (arb_req_ready),
    .req_i           (arb_req),
    .rsp_valid_o     (arb_rsp_valid),
    .rsp_ready_i     (arb_rsp_ready),
    .mem_req_valid_o (mem_req_valid),
    .mem_req_ready_i (mem_req_ready),
    .mem_req_o       (mem_req),
    .mem_rsp_valid_i (mem_rsp_valid),
    .mem_rsp_ready_o (mem_rsp_ready)
  );

  sram_wait i_sram (
    .clk         (clk),
    .rst         (rst),
    .req_valid_i (mem_req_valid),
    .req_ready_o (mem_req_ready),
    .req_i       (mem_req),
    .rsp_valid_o (mem_rsp_valid),
    .rsp_ready_i (mem_rsp_ready),
    .rsp_o       (mem_rsp)
  );

endmodule

/* tb_mem_subsys.sv */
`timescale 1ns/100ps

module tb_mem_subsys;

  localparam int CLK_PERIOD = 40;
  localparam int LAT_MAX    = 2 * (mem_pkg::WAIT_CYCLES + 2);  // One fetch ahead, then its own.
  localparam int N_ACCESS   = 12 + 3 + 12 + 20 + 8;           // Accesses over the five tests.
  localparam int LIMIT      = 2 * N_ACCESS * (mem_pkg::WAIT_CYCLES + 2) + 200;  // In cycles.

  logic                       clk = 1'b0;
  logic                       rst;
  logic                       redirect_i;
  logic [mem_pkg::ADDR_W-1:0] redirect_pc_i;
  logic                       instr_valid_o;
  logic                       instr_ready_i;
  logic [mem_pkg::DATA_W-1:0] instr_o;
  logic [mem_pkg::ADDR_W-1:0] instr_pc_o;
  logic                       dat_valid_i;
  logic                       dat_ready_o;
  mem_pkg::mem_req_t          dat_req_i;
  logic                       dat_done_o;
  logic [mem_pkg::DATA_W-1:0] dat_rdata_o;

  logic [mem_pkg::DATA_W-1:0] model [2 ** mem_pkg::ADDR_W];  // Expected memory contents.
  logic [mem_pkg::ADDR_W-1:0] exp_pc;     // PC the next delivered instruction must carry.
  logic [mem_pkg::DATA_W-1:0] exp_word;
  logic [mem_pkg::DATA_W-1:0] exp_rdata;  // Word the open data access must return.
  logic                       dat_open;   // A data access is accepted and not yet done.
  int                         dat_age;    // Edges since that acceptance, less one.
  int                         errors = 0;
  int                         err_mark = 0;
  int                         bad_tests = 0;
  logic [31:0]                seed = 32'd68;
  string                      test_name = "reset";

  mem_subsys i_dut (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  assign exp_word = model[exp_pc];

  // Same image as the SRAM. Words past the end of the file hold a tag plus their address.
  initial begin
    for (int i = 0; i < 2 ** mem_pkg::ADDR_W; i++) begin
      model[i] = 32'hC0DE_0000 + i;
    end
    $readmemh("mem_init.hex", model);
  end

  // Reference model. It steps on the same edges where the DUT takes its handshakes.
  always @(posedge clk or negedge rst) begin
    if (!rst) begin
      exp_pc   <= '0;  // The fetcher leaves reset at PC zero.
      dat_open <= 1'b0;
      dat_age  <= 0;
    end else begin
      if (redirect_i) begin
        exp_pc <= redirect_pc_i;  // What shows in this cycle is still the old stream.
      end else if (instr_valid_o && instr_ready_i) begin
        exp_pc <= exp_pc + 1'b1;
      end
      dat_age <= dat_age + 1;
      if (dat_done_o) begin
        dat_open <= 1'b0;
      end
      if (dat_valid_i && dat_ready_o) begin
        exp_rdata <= model[dat_req_i.addr];  // A store answers with the word it replaces.
        if (dat_req_i.write) begin
          model[dat_req_i.addr] = dat_req_i.wdata;
        end
        dat_open <= 1'b1;  // Wins over a done strobe on the same edge.
        dat_age  <= 0;
      end
    end
  end

  // Each delivered instruction is the next PC of the current stream and matches the model.
  a_pc: assert property (@(posedge clk) disable iff (!rst)
      instr_valid_o && !redirect_i |-> instr_pc_o == exp_pc)
    else mismatch("instr_pc_o", $sampled(exp_pc), $sampled(instr_pc_o));
  a_word: assert property (@(posedge clk) disable iff (!rst)
      instr_valid_o && !redirect_i |-> instr_o == exp_word)
    else mismatch("instr_o", $sampled(exp_word), $sampled(instr_o));
  // A stalled instruction stays on the outputs unchanged.
  a_hold: assert property (@(posedge clk) disable iff (!rst)
      instr_valid_o && !instr_ready_i && !redirect_i
      |=> instr_valid_o && $stable(instr_o) && $stable(instr_pc_o))
    else raise_failure("a stalled instruction changed or vanished");
  a_rdata: assert property (@(posedge clk) disable iff (!rst)
      dat_done_o |-> dat_open && dat_rdata_o == exp_rdata)
    else mismatch("dat_rdata_o", $sampled(exp_rdata), $sampled(dat_rdata_o));
  // Round robin lets at most one fetch transaction go ahead of a data access.
  a_late: assert property (@(posedge clk) disable iff (!rst)
      dat_open |-> dat_age < LAT_MAX)
    else raise_failure("a data access did not complete in time");

  function automatic logic [31:0] next_random();
    seed = seed * 32'd1664525 + 32'd1013904223;  // Full-period LCG modulo 2**32.
    return seed;
  endfunction

  task automatic mismatch(input string what, input logic [31:0] exp_v,
                          input logic [31:0] act_v);
    errors++;
    $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp_v, act_v);
  endtask

  task automatic raise_failure(input string what);
    errors++;
    $display("ERROR in %s: %s", test_name, what);
  endtask

  task automatic close_test(input int num);
    if (errors == err_mark) begin
      $display("Test %0d %s: passed", num, test_name);
    end else begin
      bad_tests++;
      $display("Test %0d %s: failed with %0d errors", num, test_name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  // Redirect for one cycle. The task starts and ends just after a rising edge.
  task automatic redirect_to(input logic [mem_pkg::ADDR_W-1:0] pc);
    redirect_i    = 1'b1;
    redirect_pc_i = pc;
    @(posedge clk);
    #2;
    redirect_i = 1'b0;
  endtask

  // Waits for n instruction handshakes. With stall set the core takes words at random.
  task automatic take_instrs(input int n, input logic stall);
    logic [31:0] r;
    int          got;
    got = 0;
    while (got < n) begin
      r             = next_random();
      instr_ready_i = stall ? r[16] : 1'b1;
      if (instr_valid_o && instr_ready_i) begin
        got++;  // This handshake completes on the coming edge.
      end
      @(posedge clk);
      #2;
    end
    instr_ready_i = 1'b0;  // Leaves the buffer to fill between tests.
  endtask

  // One load or store, held until it is taken and then followed to its done strobe.
  task automatic data_access(input logic write, input logic [mem_pkg::ADDR_W-1:0] addr,
                             input logic [mem_pkg::DATA_W-1:0] wdata);
    dat_valid_i = 1'b1;
    dat_req_i   = '{write: write, addr: addr, wdata: wdata};
    while (!dat_ready_o) begin
      @(posedge clk);
      #2;
    end
    @(posedge clk);  // Ready was high the whole cycle, so this edge takes the request.
    #2;
    dat_valid_i = 1'b0;
    while (!dat_done_o) begin
      @(posedge clk);
      #2;
    end
    @(posedge clk);  // The strobe is checked on this edge.
    #2;
  endtask

  initial begin
    logic [31:0]                r;
    logic [mem_pkg::ADDR_W-1:0] addr;
    rst           = 1'b0;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    instr_ready_i = 1'b0;
    dat_valid_i   = 1'b0;
    dat_req_i     = '0;
    repeat (2) @(posedge clk);
    #2;
    rst       = 1'b1;
    test_name = "reset_and_stream";
    a_reset: assert (!instr_valid_o && !dat_done_o && dat_ready_o)
      else mismatch("idle outputs", 32'b001, {instr_valid_o, dat_done_o, dat_ready_o});
    redirect_to(8'h04);
    take_instrs(12, 1'b0);
    close_test(1);

    test_name = "store_then_load";
    r    = next_random();
    addr = {4'hF, r[3:0]};  // Stores stay well above any address the fetcher reaches.
    data_access(1'b1, addr, next_random());
    data_access(1'b0, addr, '0);
    data_access(1'b0, 8'h05, '0);  // Never written, so the word from the hex file returns.
    close_test(2);

    test_name = "redirect_in_flight";
    take_instrs(4, 1'b0);
    redirect_to(8'h09);  // The fetcher has a request out at this point.
    take_instrs(8, 1'b0);
    close_test(3);

    test_name = "random_backpressure";
    redirect_to(8'h30);
    take_instrs(20, 1'b1);
    close_test(4);

    test_name     = "data_beside_fetch";
    instr_ready_i = 1'b1;  // The fetch stream runs free for the whole test.
    repeat (8) begin
      r    = next_random();
      addr = {(r[31] || r[28]) ? 4'hF : 4'h0, r[3:0]};
      data_access(r[31], addr, r[31] ? next_random() : '0);
    end
    instr_ready_i = 1'b0;
    close_test(5);

    $display("Tests run 5, tests failed %0d, check errors %0d", bad_tests, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // Ends a hung run. The limit gives every access two full SRAM turns plus slack.
  initial begin
    #(LIMIT * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles and the tests did not finish", LIMIT);
    $display("** FAIL **");
    $finish;
  end

endmodule

/* sim.f */
mem_pkg.sv
sram_wait.sv
mem_arbiter.sv
fetch_port.sv
data_port.sv
mem_subsys.sv
tb_mem_subsys.sv

/* mem_init.hex */
// One 32-bit word per line in hex, for word addresses 0x00 to 0x0F.
00000013
3c1a0001
27bd0010
8fa40004
00851020
ac820008
1440fffb
24a50001
0c000040
afbf0014
8c430000
00621824
10600003
3c08dead
3508beef
03e00008
